// ==== Bender.yml ====
package:
  name: accel_pool

dependencies: {}

sources:
  # Design sources in compile order
  - design/accelPkg.sv
  - design/addrCounter.sv
  - design/actBuffer.sv
  - design/seqCtrl.sv
  - design/poolUnit.sv
  - design/outStage.sv
  - design/accelTop.sv

  # Simulation only
  - target: simulation
    files:
      - sim/accelSva.sv
      - sim/accelTb.sv

// ==== compile.f ====
design/accelPkg.sv
design/addrCounter.sv
design/actBuffer.sv
design/seqCtrl.sv
design/poolUnit.sv
design/outStage.sv
design/accelTop.sv
sim/accelSva.sv
sim/accelTb.sv

// ==== design/accelPkg.sv ====
// Pooling engine shared types
package accelPkg;

    // ======================================================================
    // Activation lanes and words
    // ======================================================================

    // One unsigned activation lane
    parameter int ACT_WIDTH = 8;

    // Lanes per pad word
    parameter int LANES = 4;

    parameter int WORD_WIDTH = ACT_WIDTH * LANES;

    typedef logic [ACT_WIDTH-1:0] act_t;

    // Pad word, buffer word and result word share this layout
    typedef act_t [LANES-1:0] datWord_t;

    // ======================================================================
    // Header word layout
    // ======================================================================

    // Pool size K sits in the low bits of the header, 0 acts as 1
    parameter int POOL_K_WIDTH = 4;
    parameter int POOL_K_LSB = 0;

    typedef logic [POOL_K_WIDTH-1:0] poolK_t;

    // ======================================================================
    // Controller states
    // ======================================================================

    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        POOL,
        DRAIN
    } seqState_t;

endpackage

// ==== design/accelTop.sv ====
// Pooling engine top level
module accelTop
    import accelPkg::*;
#(
    parameter  int DEPTH      = 64,
    localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
    input  logic          clk,
    input  logic          rst,
    inout  wire datWord_t ioDat,
    inout  wire           ioDatVld,
    inout  wire           ioDatLast,
    inout  wire           ioDatRdy,
    output logic          datOe
);

    // Pad to core
    datWord_t              inDat;
    logic                  inVld;
    logic                  inLast;
    logic                  inRdy;

    // Buffer wiring
    logic                  bufWrEn;
    logic [ADDR_WIDTH-1:0] bufWrAddr;
    datWord_t              bufWrDat;
    logic                  bufRdEn;
    logic [ADDR_WIDTH-1:0] bufRdAddr;
    datWord_t              bufRdDat;

    // Pooling pipe
    logic                  rdValid;
    logic                  rdLast;
    poolK_t                poolK;
    logic                  resVld;
    datWord_t              resDat;
    logic                  resLast;
    logic                  resRdy;

    // Core to pad
    logic                  outVld;
    datWord_t              outDat;
    logic                  outLast;
    logic                  outDone;

    // ======================================================================
    // Pad turnaround
    // ======================================================================

    // datOe high means the engine owns data, valid and last
    assign ioDat     = datOe ? outDat  : 'z;
    assign ioDatVld  = datOe ? outVld  : 1'bz;
    assign ioDatLast = datOe ? outLast : 1'bz;
    assign ioDatRdy  = datOe ? 1'bz    : inRdy;

    assign inDat  = ioDat;
    assign inVld  = ioDatVld;
    assign inLast = ioDatLast;

    // ======================================================================
    // Instances
    // ======================================================================

    seqCtrl #(
        .DEPTH ( DEPTH )
    ) seqCtrl_inst (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .inDat     ( inDat     ),
        .inVld     ( inVld     ),
        .inLast    ( inLast    ),
        .inRdy     ( inRdy     ),
        .bufWrEn   ( bufWrEn   ),
        .bufWrAddr ( bufWrAddr ),
        .bufWrDat  ( bufWrDat  ),
        .bufRdEn   ( bufRdEn   ),
        .bufRdAddr ( bufRdAddr ),
        .rdValid   ( rdValid   ),
        .rdLast    ( rdLast    ),
        .poolK     ( poolK     ),
        .resRdy    ( resRdy    ),
        .outDone   ( outDone   ),
        .datOe     ( datOe     )
    );

    actBuffer #(
        .DEPTH ( DEPTH )
    ) actBuffer_inst (
        .clk    ( clk       ),
        .wrEn   ( bufWrEn   ),
        .wrAddr ( bufWrAddr ),
        .wrDat  ( bufWrDat  ),
        .rdEn   ( bufRdEn   ),
        .rdAddr ( bufRdAddr ),
        .rdDat  ( bufRdDat  )
    );

    poolUnit poolUnit_inst (
        .clk     ( clk      ),
        .rst     ( rst      ),
        .rdValid ( rdValid  ),
        .rdDat   ( bufRdDat ),
        .rdLast  ( rdLast   ),
        .poolK   ( poolK    ),
        .resVld  ( resVld   ),
        .resDat  ( resDat   ),
        .resLast ( resLast  ),
        .resRdy  ( resRdy   )
    );

    outStage outStage_inst (
        .clk     ( clk      ),
        .rst     ( rst      ),
        .resVld  ( resVld   ),
        .resDat  ( resDat   ),
        .resLast ( resLast  ),
        .resRdy  ( resRdy   ),
        .outVld  ( outVld   ),
        .outDat  ( outDat   ),
        .outLast ( outLast  ),
        .outRdy  ( ioDatRdy ),
        .outDone ( outDone  )
    );

endmodule

// ==== design/actBuffer.sv ====
// Activation buffer
module actBuffer
    import accelPkg::*;
#(
    parameter  int DEPTH      = 64,
    localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
    input  logic                  clk,

    // Write port
    input  logic                  wrEn,
    input  logic [ADDR_WIDTH-1:0] wrAddr,
    input  datWord_t              wrDat,

    // Read port
    input  logic                  rdEn,
    input  logic [ADDR_WIDTH-1:0] rdAddr,
    output datWord_t              rdDat
);

    // ======================================================================
    // Storage
    // ======================================================================

    datWord_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrDat;
        end
    end

    // ======================================================================
    // Registered read
    // ======================================================================

    // Word appears one cycle after rdEn and holds while rdEn is low
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdDat <= mem[rdAddr];
        end
    end

endmodule

// ==== design/addrCounter.sv ====
// Clearable counter with limit compare
module addrCounter #(
    parameter int CNT_WIDTH = 6
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 clear,
    input  logic                 step,
    input  logic [CNT_WIDTH-1:0] limit,
    output logic [CNT_WIDTH-1:0] count,
    output logic                 atLimit
);

    // ======================================================================
    // Count register
    // ======================================================================

    // Clear wins over step
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    // ======================================================================
    // Limit compare
    // ======================================================================

    // Parents end groups and packets on this flag
    assign atLimit = (count == limit);

endmodule

// ==== design/outStage.sv ====
// Output register toward the pad
module outStage
    import accelPkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // From the pooling unit
    input  logic     resVld,
    input  datWord_t resDat,
    input  logic     resLast,
    output logic     resRdy,

    // Toward the pad
    output logic     outVld,
    output datWord_t outDat,
    output logic     outLast,
    input  logic     outRdy,
    output logic     outDone
);

    // ======================================================================
    // One-entry register
    // ======================================================================

    // Empty, or emptied this cycle
    assign resRdy = !outVld || outRdy;

    always_ff @(posedge clk) begin
        if (rst) begin
            outVld <= 1'b0;
        end else if (resRdy) begin
            outVld <= resVld;
        end
    end

    // Payload loads only on a real transfer, so it stays put while stalled
    always_ff @(posedge clk) begin
        if (resRdy && resVld) begin
            outDat  <= resDat;
            outLast <= resLast;
        end
    end

    // End of packet seen by the host
    assign outDone = outVld && outRdy && outLast;

endmodule

// ==== design/poolUnit.sv ====
// Lane-wise max pooling unit
module poolUnit
    import accelPkg::*;
(
    input  logic     clk,
    input  logic     rst,

    // Words from the buffer
    input  logic     rdValid,
    input  datWord_t rdDat,
    input  logic     rdLast,
    input  poolK_t   poolK,

    // Results toward the output stage
    output logic     resVld,
    output datWord_t resDat,
    output logic     resLast,
    input  logic     resRdy
);

    datWord_t acc;
    datWord_t maxDat;
    datWord_t merged;
    poolK_t   grpCount;
    poolK_t   grpLimit;
    logic     grpAtLimit;
    logic     take;
    logic     closeGroup;

    // Everything holds while the output stage is full
    assign take       = rdValid && resRdy;
    assign closeGroup = grpAtLimit || rdLast;
    assign grpLimit   = poolK - 1'b1;

    addrCounter #(
        .CNT_WIDTH ( POOL_K_WIDTH )
    ) groupCount (
        .clk     ( clk                 ),
        .rst     ( rst                 ),
        .clear   ( take && closeGroup  ),
        .step    ( take                ),
        .limit   ( grpLimit            ),
        .count   ( grpCount            ),
        .atLimit ( grpAtLimit          )
    );

    // ======================================================================
    // Max fold
    // ======================================================================

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            maxDat[i] = (acc[i] > rdDat[i]) ? acc[i] : rdDat[i];
        end
    end

    // First word of a group restarts the accumulator
    assign merged = (grpCount == '0) ? rdDat : maxDat;

    always_ff @(posedge clk) begin
        if (take) begin
            acc <= merged;
        end
    end

    // ======================================================================
    // Result register
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            resVld <= 1'b0;
        end else if (resRdy) begin
            resVld <= rdValid && closeGroup;
        end
    end

    always_ff @(posedge clk) begin
        if (take && closeGroup) begin
            resDat  <= merged;
            resLast <= rdLast;
        end
    end

endmodule

// ==== design/seqCtrl.sv ====
// Packet sequencing controller
module seqCtrl
    import accelPkg::*;
#(
    parameter  int DEPTH      = 64,
    localparam int ADDR_WIDTH = $clog2(DEPTH)
) (
    input  logic                  clk,
    input  logic                  rst,

    // Inbound packet from the pad
    input  datWord_t              inDat,
    input  logic                  inVld,
    input  logic                  inLast,
    output logic                  inRdy,

    // Buffer ports
    output logic                  bufWrEn,
    output logic [ADDR_WIDTH-1:0] bufWrAddr,
    output datWord_t              bufWrDat,
    output logic                  bufRdEn,
    output logic [ADDR_WIDTH-1:0] bufRdAddr,

    // Pooling side, aligned to buffer read data
    output logic                  rdValid,
    output logic                  rdLast,
    output poolK_t                poolK,
    input  logic                  resRdy,
    input  logic                  outDone,

    output logic                  datOe
);

    seqState_t             state;
    logic [ADDR_WIDTH-1:0] wrAddr;
    logic [ADDR_WIDTH-1:0] rdAddr;
    logic [ADDR_WIDTH-1:0] lastAddr;
    logic                  wrFull;
    logic                  rdAtEnd;
    logic                  hdrTake;
    logic                  wrTake;
    logic                  pktEnd;
    logic                  readIssue;
    logic [WORD_WIDTH-1:0] hdrBits;
    poolK_t                kField;

    // ======================================================================
    // Inbound handshake and header decode
    // ======================================================================

    assign inRdy     = (state == IDLE) || (state == LOAD);
    assign hdrTake   = (state == IDLE) && inVld;
    assign wrTake    = (state == LOAD) && inVld;
    // A full buffer also closes the packet
    assign pktEnd    = wrTake && (inLast || wrFull);
    // Reads advance only when the pooling pipe can move
    assign readIssue = (state == POOL) && resRdy;

    assign hdrBits = inDat;
    assign kField  = hdrBits[POOL_K_LSB +: POOL_K_WIDTH];

    assign bufWrEn   = wrTake;
    assign bufWrAddr = wrAddr;
    assign bufWrDat  = inDat;
    assign bufRdEn   = readIssue;
    assign bufRdAddr = rdAddr;

    addrCounter #(
        .CNT_WIDTH ( ADDR_WIDTH )
    ) wrCount (
        .clk     ( clk                       ),
        .rst     ( rst                       ),
        .clear   ( state == IDLE             ),
        .step    ( wrTake                    ),
        .limit   ( ADDR_WIDTH'(DEPTH - 1)    ),
        .count   ( wrAddr                    ),
        .atLimit ( wrFull                    )
    );

    addrCounter #(
        .CNT_WIDTH ( ADDR_WIDTH )
    ) rdCount (
        .clk     ( clk           ),
        .rst     ( rst           ),
        .clear   ( state != POOL ),
        .step    ( readIssue     ),
        .limit   ( lastAddr      ),
        .count   ( rdAddr        ),
        .atLimit ( rdAtEnd       )
    );

    // ======================================================================
    // State machine
    // ======================================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            datOe    <= 1'b0;
            poolK    <= poolK_t'(1);
            lastAddr <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (hdrTake) begin
                        poolK <= (kField == '0) ? poolK_t'(1) : kField;
                        state <= LOAD;
                    end
                end
                LOAD: begin
                    if (pktEnd) begin
                        lastAddr <= wrAddr;
                        state    <= POOL;
                        // Bus turns around for the results
                        datOe    <= 1'b1;
                    end
                end
                POOL: begin
                    if (readIssue && rdAtEnd) begin
                        state <= DRAIN;
                    end
                end
                DRAIN: begin
                    if (outDone) begin
                        state <= IDLE;
                        datOe <= 1'b0;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Read tags follow the buffer latency, frozen during a stall
    always_ff @(posedge clk) begin
        if (rst) begin
            rdValid <= 1'b0;
            rdLast  <= 1'b0;
        end else if (resRdy) begin
            rdValid <= readIssue;
            rdLast  <= readIssue && rdAtEnd;
        end
    end

endmodule

// ==== sim/accelSva.sv ====
// Pad handshake assertions
module accelSva
    import accelPkg::*;
(
    input logic     clk,
    input logic     rst,
    input logic     datOe,
    input datWord_t ioDat,
    input logic     ioDatVld,
    input logic     ioDatLast,
    input logic     ioDatRdy,
    input logic     outVld
);

    int failCount = 0;

    // ======================================================================
    // Held words while stalled
    // ======================================================================

    // Engine keeps its result until the host takes it
    property engineHold;
        @(posedge clk) disable iff (rst)
        (datOe && ioDatVld && !ioDatRdy) |=>
            (datOe && ioDatVld && $stable(ioDat) && $stable(ioDatLast));
    endproperty

    // ======================================================================
    // Bus direction
    // ======================================================================

    property resetDatOe;
        @(posedge clk) rst |=> !datOe;
    endproperty

    property noValidInbound;
        @(posedge clk) disable iff (rst) !datOe |-> !outVld;
    endproperty

    assert property (engineHold) else begin
        failCount++;
        $error("engine word changed while stalled");
    end

    assert property (resetDatOe) else begin
        failCount++;
        $error("datOe high after reset");
    end

    assert property (noValidInbound) else begin
        failCount++;
        $error("output valid while bus is inbound");
    end

endmodule

bind accelTop accelSva accelSva_inst (
    .clk       ( clk       ),
    .rst       ( rst       ),
    .datOe     ( datOe     ),
    .ioDat     ( ioDat     ),
    .ioDatVld  ( ioDatVld  ),
    .ioDatLast ( ioDatLast ),
    .ioDatRdy  ( ioDatRdy  ),
    .outVld    ( outVld    )
);

// ==== sim/accelTb.sv ====
// Pooling engine testbench
module accelTb
    import accelPkg::*;
();

    typedef datWord_t wordQ_t[$];

    // Packet list, one entry per test
    localparam int NUM_TESTS = 13;
    localparam int TEST_K [NUM_TESTS] = '{1, 2, 4, 8, 3, 5, 8, 0, 15, 2, 4, 1, 7};
    localparam int TEST_N [NUM_TESTS] = '{8, 8, 16, 16, 10, 7, 3, 6, 1, 13, 64, 64, 20};
    localparam bit TEST_BP [NUM_TESTS] = '{0, 0, 0, 0, 0, 0, 0, 0, 0, 1, 1, 0, 1};

    logic     clk;
    logic     rst;
    datWord_t hostDat;
    logic     hostVld;
    logic     hostLast;
    logic     hostRdy;
    wire      datOe;

    wire datWord_t ioDat;
    wire           ioDatVld;
    wire           ioDatLast;
    wire           ioDatRdy;

    int       seed = 56477;
    wordQ_t   expQ;
    bit       expLastQ[$];
    bit       backPressure = 1'b0;
    bit       lastSeen = 1'b0;

    // ======================================================================
    // Host side of the pad
    // ======================================================================

    assign ioDat     = datOe ? 'z   : hostDat;
    assign ioDatVld  = datOe ? 1'bz : hostVld;
    assign ioDatLast = datOe ? 1'bz : hostLast;
    assign ioDatRdy  = datOe ? hostRdy : 1'bz;

    accelTop #(
        .DEPTH ( 64 )
    ) accelTop_inst (
        .clk       ( clk       ),
        .rst       ( rst       ),
        .ioDat     ( ioDat     ),
        .ioDatVld  ( ioDatVld  ),
        .ioDatLast ( ioDatLast ),
        .ioDatRdy  ( ioDatRdy  ),
        .datOe     ( datOe     )
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    task automatic stopOnError(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "stopping on first error");
    endtask

    // Expected results: lane-wise max over groups of K, last group may be short
    function automatic wordQ_t poolRef(input wordQ_t words, input int k);
        wordQ_t   res;
        datWord_t best;
        int       kEff;
        kEff = (k == 0) ? 1 : k;
        for (int s = 0; s < words.size(); s += kEff) begin
            best = words[s];
            for (int j = s + 1; j < s + kEff && j < words.size(); j++) begin
                for (int l = 0; l < LANES; l++) begin
                    if (words[j][l] > best[l]) begin
                        best[l] = words[j][l];
                    end
                end
            end
            res.push_back(best);
        end
        return res;
    endfunction

    // Header first, then the data words, last on the final one
    task automatic sendPacket(input int k, input wordQ_t words);
        logic [WORD_WIDTH-1:0] hdrBits;
        hdrBits = $random(seed);
        hdrBits[POOL_K_WIDTH-1:0] = POOL_K_WIDTH'(k);
        for (int i = 0; i <= words.size(); i++) begin
            @(negedge clk);
            hostVld = 1'b1;
            if (i == 0) begin
                hostDat  = hdrBits;
                hostLast = 1'b0;
            end else begin
                hostDat  = words[i-1];
                hostLast = (i == words.size());
            end
            // Ready depends on state only, so it is settled here
            while (ioDatRdy !== 1'b1) begin
                @(negedge clk);
            end
        end
        @(negedge clk);
        hostVld  = 1'b0;
        hostLast = 1'b0;
        assert (datOe === 1'b1)
            else stopOnError("datOe did not rise in the cycle after the last data word");
    endtask

    // ======================================================================
    // Output ready and comparison
    // ======================================================================

    initial begin : outMonitor
        datWord_t expDat;
        bit       expLast;
        forever begin
            @(negedge clk);
            if (lastSeen) begin
                assert (datOe === 1'b0)
                    else stopOnError("datOe still high after the final result was taken");
                lastSeen = 1'b0;
            end
            hostRdy = backPressure ? 1'($random(seed)) : 1'b1;
            // Transfer happens on the coming rising edge
            if (datOe === 1'b1 && ioDatVld === 1'b1 && hostRdy) begin
                assert (expQ.size() != 0)
                    else stopOnError("engine sent a result when none was expected");
                expDat  = expQ.pop_front();
                expLast = expLastQ.pop_front();
                assert (ioDat === expDat)
                    else stopOnError($sformatf("FAIL ioDat got 0x%08h expected 0x%08h",
                                               ioDat, expDat));
                assert (ioDatLast === expLast)
                    else stopOnError($sformatf("FAIL ioDatLast got 0x%0h expected 0x%0h",
                                               ioDatLast, expLast));
                lastSeen = expLast;
            end
        end
    end

    // Budget of 20 cycles per word sent
    initial begin : watchdog
        int totalWords;
        totalWords = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            totalWords += TEST_N[t] + 1;
        end
        repeat (10 + 20 * totalWords) @(posedge clk);
        $display("Timeout: no end of run after %0d cycles", 10 + 20 * totalWords);
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin : mainSeq
        wordQ_t words;
        wordQ_t expRes;
        rst      = 1'b1;
        hostDat  = '0;
        hostVld  = 1'b0;
        hostLast = 1'b0;
        hostRdy  = 1'b1;
        repeat (10) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        assert (datOe === 1'b0)
            else stopOnError("datOe is not low after reset");
        assert (ioDatRdy === 1'b1)
            else stopOnError("ioDatRdy is not high after reset");

        for (int t = 0; t < NUM_TESTS; t++) begin
            words.delete();
            for (int i = 0; i < TEST_N[t]; i++) begin
                words.push_back(datWord_t'($random(seed)));
            end
            expRes = poolRef(words, TEST_K[t]);
            foreach (expRes[i]) begin
                expQ.push_back(expRes[i]);
                expLastQ.push_back(i == expRes.size() - 1);
            end
            backPressure = TEST_BP[t];
            sendPacket(TEST_K[t], words);
            // Bus comes back to the host after the last result
            while (datOe !== 1'b0) begin
                @(negedge clk);
            end
            assert (expQ.size() == 0)
                else stopOnError($sformatf("packet %0d ended with %0d results missing",
                                           t, expQ.size()));
            assert (ioDatRdy === 1'b1)
                else stopOnError("ioDatRdy is not high between packets");
            $display("Packet %0d done: K=%0d N=%0d results=%0d",
                     t, TEST_K[t], TEST_N[t], expRes.size());
        end

        if (accelTop_inst.accelSva_inst.failCount == 0) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "bound assertions failed");
        end
    end

endmodule
